/* design/prefetch_cfg_pkg.sv */
package prefetch_cfg_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [31:0] count_t;    // Line counts

    // Register map, byte offsets
    localparam apb_addr_t reg_ctrl      = 8'h00;
    localparam apb_addr_t reg_status    = 8'h04;
    localparam apb_addr_t reg_base      = 8'h08;
    localparam apb_addr_t reg_length    = 8'h0C;
    localparam apb_addr_t reg_delivered = 8'h10;

    localparam int ctrl_start_bit  = 0;   // Write 1 to start
    localparam int status_busy_bit = 0;
    localparam int status_done_bit = 1;   // Sticky, cleared by start

endpackage

/* design/prefetch_mem_pkg.sv */
package prefetch_mem_pkg;

    // Addresses count in lines, not bytes
    typedef logic [31:0] line_addr_t;

    // One memory line, also the stream payload
    typedef logic [63:0] line_t;

endpackage

/* design/prefetch_ctrl_if.sv */
`timescale 1ns/1ps

interface prefetch_ctrl_if
    import prefetch_cfg_pkg::*;
    import prefetch_mem_pkg::*;
();
    logic       start;       // One cycle pulse
    line_addr_t base;
    count_t     length;
    logic       busy;
    logic       done_pulse;
    count_t     delivered;

    modport regs_side
    (
        output start,
        output base,
        output length,
        input  busy,
        input  done_pulse,
        input  delivered
    );

    modport engine_side
    (
        input  start,
        input  base,
        input  length,
        output busy,
        output done_pulse,
        output delivered
    );

endinterface

/* design/line_fifo.sv */
`timescale 1ns/1ps

module line_fifo
    import prefetch_mem_pkg::*;
#(
    parameter int DEPTH = 8
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  line_t                    wr_data,
    output logic                     rd_valid,
    input  logic                     rd_ready,
    output line_t                    rd_data,
    output logic [$clog2(DEPTH):0]   count
);

    localparam int AW = $clog2(DEPTH);

    line_t          mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic           rd_fire;

    // Head entry is always presented
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign rd_fire  = rd_valid && rd_ready;

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            wr_ptr <= wr_ptr + AW'(wr_en);   // Pointers wrap, DEPTH is a power of two
            rd_ptr <= rd_ptr + AW'(rd_fire);
            case ({wr_en, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/prefetch_regs.sv */
`timescale 1ns/1ps

module prefetch_regs
    import prefetch_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // APB slave, zero wait
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pslverr,

    prefetch_ctrl_if.regs_side ctrl
);

    logic access;
    logic wr_en;
    logic mapped;
    logic done;

    assign access  = psel && penable;
    assign wr_en   = access && pwrite;
    assign pslverr = access && !mapped;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl.start  <= 1'b0;
            ctrl.base   <= '0;
            ctrl.length <= '0;
            done        <= 1'b0;
        end
        else
        begin
            // Start is dropped while an operation runs
            ctrl.start <= wr_en && (paddr == reg_ctrl) && pwdata[ctrl_start_bit]
                          && !ctrl.busy && !ctrl.start;
            if (wr_en && (paddr == reg_base))
                ctrl.base <= pwdata;
            if (wr_en && (paddr == reg_length))
                ctrl.length <= pwdata;
            if (ctrl.start)
                done <= 1'b0;
            else if (ctrl.done_pulse)
                done <= 1'b1;
        end
    end

    // Read mux and offset decode
    always_comb
    begin
        prdata = '0;
        mapped = 1'b1;
        case (paddr)
            reg_ctrl:      prdata = '0;   // Start bit reads back zero
            reg_status:
            begin
                prdata[status_busy_bit] = ctrl.busy;
                prdata[status_done_bit] = done;
            end
            reg_base:      prdata = ctrl.base;
            reg_length:    prdata = ctrl.length;
            reg_delivered: prdata = ctrl.delivered;
            default:       mapped = 1'b0;
        endcase
    end

endmodule

/* design/prefetch_engine.sv */
`timescale 1ns/1ps

module prefetch_engine
    import prefetch_cfg_pkg::*;
    import prefetch_mem_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
)
(
    input  logic       clk,
    input  logic       reset,

    prefetch_ctrl_if.engine_side ctrl,

    output logic       mem_req_valid,
    input  logic       mem_req_ready,
    output line_addr_t mem_req_addr,
    input  logic       mem_rsp_valid,
    input  line_t      mem_rsp_data,

    output logic       line_valid,
    input  logic       line_ready,
    output line_t      line_data
);

    localparam int CW = $clog2(FIFO_DEPTH) + 1;

    typedef enum logic {state_idle, state_read} state_t;

    state_t        state;
    line_addr_t    base_q;
    count_t        length_q;
    count_t        req_cnt;          // Lines issued so far
    count_t        delivered_cnt;
    count_t        delivered_next;
    logic [CW-1:0] in_flight;        // Issued, response not yet back
    logic [CW-1:0] fifo_count;
    logic [CW-1:0] credit;
    logic          issue;
    logic          line_fire;
    logic          finish;

    line_fifo #(.DEPTH(FIFO_DEPTH)) line_buf
    (
        .clk,
        .reset,
        .wr_en    (mem_rsp_valid),
        .wr_data  (mem_rsp_data),
        .rd_valid (line_valid),
        .rd_ready (line_ready),
        .rd_data  (line_data),
        .count    (fifo_count)
    );

    // A request held in the output register already owns its credit
    assign credit = CW'(FIFO_DEPTH) - (in_flight + fifo_count);
    assign issue  = (state == state_read) && (!mem_req_valid || mem_req_ready)
                    && (req_cnt < length_q) && (credit != '0);

    assign line_fire      = line_valid && line_ready;
    assign delivered_next = delivered_cnt + count_t'(line_fire);
    assign finish         = (state == state_read) && (delivered_next == length_q);

    assign ctrl.busy      = (state == state_read);
    assign ctrl.delivered = delivered_cnt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state           <= state_idle;
            req_cnt         <= '0;
            delivered_cnt   <= '0;
            in_flight       <= '0;
            mem_req_valid   <= 1'b0;
            ctrl.done_pulse <= 1'b0;
        end
        else
        begin
            ctrl.done_pulse <= 1'b0;

            if (issue)
            begin
                mem_req_valid <= 1'b1;
                req_cnt       <= req_cnt + 1'b1;
            end
            else if (mem_req_ready)
                mem_req_valid <= 1'b0;

            case ({issue, mem_rsp_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase

            case (state)
                state_idle:
                begin
                    if (ctrl.start)
                    begin
                        req_cnt       <= '0;
                        delivered_cnt <= '0;
                        state         <= state_read;
                    end
                end
                state_read:
                begin
                    delivered_cnt <= delivered_next;
                    if (finish)   // Covers length 0 too
                    begin
                        state           <= state_idle;
                        ctrl.done_pulse <= 1'b1;
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == state_idle) && ctrl.start)
        begin
            base_q   <= ctrl.base;
            length_q <= ctrl.length;
        end
        if (issue)
            mem_req_addr <= base_q + line_addr_t'(req_cnt);
    end

endmodule

/* design/prefetch_top.sv */
`timescale 1ns/1ps

module prefetch_top
    import prefetch_cfg_pkg::*;
    import prefetch_mem_pkg::*;
#(
    parameter int FIFO_DEPTH = 8   // Power of two
)
(
    input  logic       clk,
    input  logic       reset,

    // APB
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pslverr,

    // Memory read port
    output logic       mem_req_valid,
    input  logic       mem_req_ready,
    output line_addr_t mem_req_addr,
    input  logic       mem_rsp_valid,
    input  line_t      mem_rsp_data,

    // Line stream to the consumer
    output logic       line_valid,
    input  logic       line_ready,
    output line_t      line_data
);

    prefetch_ctrl_if ctrl_if ();

    prefetch_regs regs0
    (
        .clk,
        .reset,
        .psel,
        .penable,
        .pwrite,
        .paddr,
        .pwdata,
        .prdata,
        .pslverr,
        .ctrl (ctrl_if.regs_side)
    );

    prefetch_engine #(.FIFO_DEPTH(FIFO_DEPTH)) engine0
    (
        .clk,
        .reset,
        .ctrl (ctrl_if.engine_side),
        .mem_req_valid,
        .mem_req_ready,
        .mem_req_addr,
        .mem_rsp_valid,
        .mem_rsp_data,
        .line_valid,
        .line_ready,
        .line_data
    );

endmodule

/* dv/prefetch_assertions.sv */
`timescale 1ns/1ps

module prefetch_assertions
    import prefetch_mem_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
)
(
    input logic                          clk,
    input logic                          reset,
    input logic                          mem_req_valid,
    input logic                          mem_rsp_valid,
    input logic                          line_valid,
    input logic                          line_ready,
    input line_t                         line_data,
    input logic [$clog2(FIFO_DEPTH):0]   in_flight,
    input logic [$clog2(FIFO_DEPTH):0]   fifo_count
);

    int unsigned fail_count = 0;   // Read by the testbench

    // Lines in flight plus lines held stay within the buffer
    credit_a: assert property (@(posedge clk) disable iff (reset)
        (int'(in_flight) + int'(fifo_count)) <= FIFO_DEPTH)
    else
    begin
        $error("credit budget exceeded");
        fail_count++;
    end

    no_overflow_a: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid |-> (int'(fifo_count) < FIFO_DEPTH))
    else
    begin
        $error("response written into a full line buffer");
        fail_count++;
    end

    stream_hold_a: assert property (@(posedge clk) disable iff (reset)
        (line_valid && !line_ready) |=> (line_valid && $stable(line_data)))
    else
    begin
        $error("line stream changed while stalled");
        fail_count++;
    end

    reset_state_a: assert property (@(posedge clk)
        reset |=> (!mem_req_valid && !line_valid && (in_flight == '0)))
    else
    begin
        $error("engine not idle after reset");
        fail_count++;
    end

endmodule

bind prefetch_engine prefetch_assertions #(.FIFO_DEPTH(FIFO_DEPTH)) assert0
(
    .clk,
    .reset,
    .mem_req_valid,
    .mem_rsp_valid,
    .line_valid,
    .line_ready,
    .line_data,
    .in_flight,
    .fifo_count
);

/* dv/prefetch_tb.sv */
`timescale 1ns/1ps

module prefetch_tb
    import prefetch_cfg_pkg::*;
    import prefetch_mem_pkg::*;
();

    localparam int FIFO_DEPTH = 8;
    localparam int max_cycles = 60 * 12 + 1000;   // About 60 lines over all tests

    logic       clk, reset, psel, penable, pwrite, pslverr;
    logic       mem_req_valid, mem_req_ready, mem_rsp_valid, line_valid, line_ready;
    apb_addr_t  paddr;
    apb_data_t  pwdata, prdata, rd;
    line_addr_t mem_req_addr, exp_base;
    line_t      mem_rsp_data, line_data;
    count_t     run_idx;                        // Lines seen in the current run
    logic       err, stall;
    int         seed = 48;
    int         rnd, fires_before;
    int         next_lat = 0;
    int         cyc = 0, mem_fires = 0, lines_seen = 0;
    line_addr_t addr_q[$];                      // Accepted requests, oldest first
    int         due_q[$];

    prefetch_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (.*);

    // Memory contents for a line address
    function automatic line_t line_pattern(line_addr_t addr);
        return {addr * 32'h9E37_79B1, addr ^ 32'hA5C3_0F1E};
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_line(string name, line_t got, line_t exp);
        if (got !== exp)
            abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h",
                                $time, name, got, exp));
    endtask

    task automatic check_word(string name, apb_data_t got, apb_data_t exp);
        if (got !== exp)
            abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h",
                                $time, name, got, exp));
    endtask

    task automatic next_cycle(int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // Setup then access phase, read data taken mid access
    task automatic apb_xfer(logic write, apb_addr_t addr, apb_data_t data);
        psel    = 1'b1;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        next_cycle(1);
        penable = 1'b1;
        @(negedge clk);
        rd  = prdata;
        err = pslverr;
        next_cycle(1);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic expect_reg(apb_addr_t addr, apb_data_t exp, string name);
        apb_xfer(1'b0, addr, '0);
        check_word(name, rd, exp);
    endtask

    task automatic start_run(line_addr_t base, count_t length);
        exp_base = base;
        run_idx  = '0;
        apb_xfer(1'b1, reg_base, base);
        apb_xfer(1'b1, reg_length, length);
        apb_xfer(1'b1, reg_ctrl, 32'h1);
    endtask

    task automatic finish_run(count_t length);
        rd = '0;
        while (!rd[status_done_bit])
            apb_xfer(1'b0, reg_status, '0);
        check_word("lines received", run_idx, length);
        expect_reg(reg_status, 32'h2, "status");
        expect_reg(reg_delivered, length, "delivered");
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc++;
        if (cyc >= max_cycles)
            abort_run("timeout: operation never completed");
    end

    // Memory model and consumer, one random draw per cycle
    always @(posedge clk)
    begin
        #10;
        rnd           = $random(seed);
        mem_req_ready = rnd[0];
        line_ready    = rnd[1] && !stall;
        next_lat      = rnd[3:2];               // Extra response delay
        mem_rsp_valid = (addr_q.size() != 0) && (due_q[0] <= cyc);
        if (mem_rsp_valid)
        begin
            mem_rsp_data = line_pattern(addr_q.pop_front());
            due_q.delete(0);
        end
    end

    // Handshakes are taken mid cycle where all signals are settled
    always @(negedge clk)
    begin
        if (mem_req_valid && mem_req_ready)
        begin
            addr_q.push_back(mem_req_addr);
            due_q.push_back(cyc + 1 + next_lat);
            mem_fires++;
        end
        if (line_valid && line_ready)
        begin
            check_line("line_data", line_data, line_pattern(exp_base + run_idx));
            run_idx++;
            lines_seen++;
        end
        if (mem_fires - lines_seen > FIFO_DEPTH)
            abort_run("memory accepted more lines than the buffer can hold");
        if (dut0.engine0.assert0.fail_count != 0)
            abort_run("a bound assertion on prefetch_engine failed");
    end

    initial
    begin
        reset         = 1'b1;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        line_ready    = 1'b0;
        stall         = 1'b0;
        exp_base      = '0;
        run_idx       = '0;
        next_cycle(5);
        reset = 1'b0;

        check_word("mem_req_valid", apb_data_t'(mem_req_valid), '0);
        check_word("line_valid", apb_data_t'(line_valid), '0);
        expect_reg(reg_status, '0, "status");
        expect_reg(reg_base, '0, "base");
        expect_reg(reg_length, '0, "length");
        expect_reg(reg_delivered, '0, "delivered");

        start_run(32'h100, 20);
        finish_run(20);

        // Consumer stalls until buffer and credits run out
        start_run(32'h2000, 20);
        @(negedge clk);
        stall = 1'b1;
        repeat (200) @(posedge clk);
        @(negedge clk);
        check_word("lines outstanding", apb_data_t'(mem_fires - lines_seen),
                   apb_data_t'(FIFO_DEPTH));        // Buffer full
        check_word("mem_req_valid", apb_data_t'(mem_req_valid), '0);
        stall = 1'b0;
        next_cycle(1);
        finish_run(20);

        // Second start while busy is dropped
        start_run(32'h300, 12);
        expect_reg(reg_status, 32'h1, "status");
        apb_xfer(1'b1, reg_ctrl, 32'h1);
        expect_reg(reg_base, 32'h300, "base");
        expect_reg(reg_length, 32'd12, "length");
        finish_run(12);
        apb_xfer(1'b1, reg_base, 32'h400);
        expect_reg(reg_status, 32'h2, "status");   // Done holds until start
        start_run(32'h400, 8);                   // Done clears here
        expect_reg(reg_status, 32'h1, "status");
        finish_run(8);

        fires_before = mem_fires;
        start_run(32'h500, 0);
        finish_run(0);
        check_word("memory requests", apb_data_t'(mem_fires - fires_before), '0);
        apb_xfer(1'b0, 8'h14, '0);
        check_word("pslverr", apb_data_t'(err), 32'h1);
        check_word("prdata", rd, '0);

        if (dut0.engine0.assert0.fail_count == 0)
        begin
            $display("TB PASSED");
            $finish;
        end
        else
            abort_run("bound assertions failed during the run");
    end

endmodule

/* verilog.f */
design/prefetch_cfg_pkg.sv
design/prefetch_mem_pkg.sv
design/prefetch_ctrl_if.sv
design/line_fifo.sv
design/prefetch_regs.sv
design/prefetch_engine.sv
design/prefetch_top.sv
dv/prefetch_assertions.sv
dv/prefetch_tb.sv

/* Bender.yml */
package:
  name: prefetch

sources:
  - design/prefetch_cfg_pkg.sv
  - design/prefetch_mem_pkg.sv
  - design/prefetch_ctrl_if.sv
  - design/line_fifo.sv
  - design/prefetch_regs.sv
  - design/prefetch_engine.sv
  - design/prefetch_top.sv
  - target: test
    files:
      - dv/prefetch_assertions.sv
      - dv/prefetch_tb.sv
